/* Bender.yml */
package:
  name: reservation_station

sources:
  - verilog/rs_pkg.sv
  - verilog/rs_alloc.sv
  - verilog/rs_entries.sv
  - verilog/rs_select.sv
  - verilog/rs_issue_reg.sv
  - verilog/rs_top.sv
  - target: simulation
    files:
      - sim/rs_chk.sv
      - sim/rs_tb.sv

/* list.f */
verilog/rs_pkg.sv
verilog/rs_alloc.sv
verilog/rs_entries.sv
verilog/rs_select.sv
verilog/rs_issue_reg.sv
verilog/rs_top.sv
sim/rs_chk.sv
sim/rs_tb.sv

/* sim/rs_chk.sv */
`timescale 1ns/1ps

module rs_chk (
    input logic                         clock,
    input logic                         reset,
    input rs_pkg::count_t               open_entries,
    input logic [rs_pkg::NUM_ALU-1:0]   alu_busy,
    input logic [rs_pkg::NUM_ALU-1:0]   alu_valid,
    input logic [rs_pkg::NUM_MULT-1:0]  mult_busy,
    input logic [rs_pkg::NUM_MULT-1:0]  mult_valid
);
    import rs_pkg::*;

    // Number of assertion failures so far
    int failures = 0;

    assert property (@(posedge clock) disable iff (reset) open_entries <= DISPATCH_WIDTH)
        else begin
            failures++;
            $error("open_entries above the dispatch width");
        end

    assert property (@(posedge clock) reset |=> (alu_valid == '0 && mult_valid == '0))
        else begin
            failures++;
            $error("issue valid high in the cycle after reset");
        end

    // A busy unit gets no grant, so its valid drops the next cycle
    for (genvar u = 0; u < NUM_ALU; u++) begin : g_alu
        assert property (@(posedge clock) disable iff (reset)
            (alu_valid[u] && alu_busy[u]) |=> !alu_valid[u])
            else begin
                failures++;
                $error("ALU %0d valid held while busy", u);
            end
    end

    for (genvar u = 0; u < NUM_MULT; u++) begin : g_mult
        assert property (@(posedge clock) disable iff (reset)
            (mult_valid[u] && mult_busy[u]) |=> !mult_valid[u])
            else begin
                failures++;
                $error("multiplier %0d valid held while busy", u);
            end
    end

endmodule

bind rs_top rs_chk chk (
    .clock        (clock),
    .reset        (reset),
    .open_entries (open_entries),
    .alu_busy     (alu_busy),
    .alu_valid    (alu_valid),
    .mult_busy    (mult_busy),
    .mult_valid   (mult_valid)
);

/* sim/rs_tb.sv */
`timescale 1ns/1ps

module rs_tb;
    import rs_pkg::*;

    localparam int RANDOM_CYCLES  = 1000;
    localparam int TIMEOUT_CYCLES = 2 * RANDOM_CYCLES;
    localparam int NUM_SLOTS      = NUM_ALU + NUM_MULT;
    localparam int DATA_BITS      = OP_BITS + 3 * TAG_BITS + BR_MASK_BITS;

    logic clock;
    logic reset;
    logic      [DISPATCH_WIDTH-1:0] dispatch_valid;
    fu_class_e [DISPATCH_WIDTH-1:0] dispatch_class;
    op_t       [DISPATCH_WIDTH-1:0] dispatch_op;
    tag_t      [DISPATCH_WIDTH-1:0] dispatch_dest;
    tag_t      [DISPATCH_WIDTH-1:0] dispatch_src1;
    logic      [DISPATCH_WIDTH-1:0] dispatch_src1_ready;
    tag_t      [DISPATCH_WIDTH-1:0] dispatch_src2;
    logic      [DISPATCH_WIDTH-1:0] dispatch_src2_ready;
    br_mask_t  [DISPATCH_WIDTH-1:0] dispatch_br_mask;
    count_t                         open_entries;
    logic      [CDB_WIDTH-1:0]      cdb_valid;
    tag_t      [CDB_WIDTH-1:0]      cdb_tag;
    logic                           squash_valid;
    br_mask_t                       squash_mask;
    logic      [NUM_ALU-1:0]        alu_busy;
    logic      [NUM_ALU-1:0]        alu_valid;
    op_t       [NUM_ALU-1:0]        alu_op;
    tag_t      [NUM_ALU-1:0]        alu_dest;
    tag_t      [NUM_ALU-1:0]        alu_src1;
    tag_t      [NUM_ALU-1:0]        alu_src2;
    br_mask_t  [NUM_ALU-1:0]        alu_br_mask;
    logic      [NUM_MULT-1:0]       mult_busy;
    logic      [NUM_MULT-1:0]       mult_valid;
    op_t       [NUM_MULT-1:0]       mult_op;
    tag_t      [NUM_MULT-1:0]       mult_dest;
    tag_t      [NUM_MULT-1:0]       mult_src1;
    tag_t      [NUM_MULT-1:0]       mult_src2;
    br_mask_t  [NUM_MULT-1:0]       mult_br_mask;

    // Reference copy of the entry table and of the issue registers
    slot_mask_t m_valid;
    logic       m_class [RS_DEPTH];
    op_t        m_op    [RS_DEPTH];
    tag_t       m_dest  [RS_DEPTH];
    tag_t       m_src1  [RS_DEPTH];
    tag_t       m_src2  [RS_DEPTH];
    logic       m_rdy1  [RS_DEPTH];
    logic       m_rdy2  [RS_DEPTH];
    br_mask_t   m_mask  [RS_DEPTH];
    logic       h_valid [NUM_SLOTS];
    logic [DATA_BITS-1:0] h_data [NUM_SLOTS];
    br_mask_t   h_mask  [NUM_SLOTS];

    string test_name;
    int    seed;
    int    errors = 0;
    int    cycles = 0;

    rs_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic fail_value(string what, logic [31:0] expected, logic [31:0] actual);
        errors++;
        $display("CHECK FAILED [%s] %s: expected 0x%0h, actual 0x%0h",
                 test_name, what, expected, actual);
        $display("Test failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    function automatic bit squashed(br_mask_t mask);
        return squash_valid && ((mask & squash_mask) != '0);
    endfunction

    function automatic int model_open();
        int free_cnt;
        free_cnt = 0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            free_cnt += !m_valid[j];
        end
        return (free_cnt < DISPATCH_WIDTH) ? free_cnt : DISPATCH_WIDTH;
    endfunction

    // Advances the reference state across one rising edge with the current inputs
    function automatic void model_step();
        slot_mask_t hit;
        slot_mask_t taken;
        slot_mask_t next_valid;
        logic       busy;
        int         lane;
        taken = '0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            hit[j] = m_valid[j] && squashed(m_mask[j]);
        end
        // Unit slots below NUM_ALU are ALUs, the rest multipliers
        for (int u = 0; u < NUM_SLOTS; u++) begin
            if (u < NUM_ALU) begin
                busy = alu_busy[u];
            end else begin
                busy = mult_busy[u - NUM_ALU];
            end
            h_valid[u] = 1'b0;
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (!busy && !h_valid[u] && m_valid[j] && !hit[j] && !taken[j] &&
                    m_rdy1[j] && m_rdy2[j] && m_class[j] == (u >= NUM_ALU)) begin
                    taken[j]   = 1'b1;
                    h_valid[u] = 1'b1;
                    h_data[u]  = {m_op[j], m_dest[j], m_src1[j], m_src2[j], m_mask[j]};
                    h_mask[u]  = m_mask[j];
                end
            end
        end
        for (int j = 0; j < RS_DEPTH; j++) begin
            for (int c = 0; c < CDB_WIDTH; c++) begin
                if (m_valid[j] && cdb_valid[c] && cdb_tag[c] == m_src1[j]) begin
                    m_rdy1[j] = 1'b1;
                end
                if (m_valid[j] && cdb_valid[c] && cdb_tag[c] == m_src2[j]) begin
                    m_rdy2[j] = 1'b1;
                end
            end
        end
        next_valid = m_valid & ~hit & ~taken;
        lane = 0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            if (!m_valid[j]) begin
                if (lane < DISPATCH_WIDTH) begin
                    if (dispatch_valid[lane] && !squashed(dispatch_br_mask[lane])) begin
                        next_valid[j] = 1'b1;
                        m_class[j] = dispatch_class[lane];
                        m_op[j]    = dispatch_op[lane];
                        m_dest[j]  = dispatch_dest[lane];
                        m_src1[j]  = dispatch_src1[lane];
                        m_src2[j]  = dispatch_src2[lane];
                        m_rdy1[j]  = dispatch_src1_ready[lane];
                        m_rdy2[j]  = dispatch_src2_ready[lane];
                        m_mask[j]  = dispatch_br_mask[lane];
                    end
                end
                lane++;
            end
        end
        m_valid = next_valid;
    endfunction

    task automatic check_outputs();
        logic                 exp_valid;
        logic                 act_valid;
        logic [DATA_BITS-1:0] act_data;
        assert (open_entries == model_open())
            else fail_value("open_entries", model_open(), open_entries);
        for (int u = 0; u < NUM_SLOTS; u++) begin
            if (u < NUM_ALU) begin
                act_valid = alu_valid[u];
                act_data  = {alu_op[u], alu_dest[u], alu_src1[u], alu_src2[u], alu_br_mask[u]};
            end else begin
                act_valid = mult_valid[u - NUM_ALU];
                act_data  = {mult_op[u - NUM_ALU], mult_dest[u - NUM_ALU],
                             mult_src1[u - NUM_ALU], mult_src2[u - NUM_ALU],
                             mult_br_mask[u - NUM_ALU]};
            end
            exp_valid = h_valid[u] && !squashed(h_mask[u]);
            assert (act_valid === exp_valid)
                else fail_value($sformatf("valid of unit slot %0d", u), exp_valid, act_valid);
            assert (!exp_valid || act_data === h_data[u])
                else fail_value($sformatf("op,dest,src1,src2,mask of unit slot %0d", u),
                                h_data[u], act_data);
        end
    endtask

    // Outputs are compared mid-cycle, then the model takes the coming edge
    always @(negedge clock) begin
        if (reset) begin
            m_valid = '0;
            for (int u = 0; u < NUM_SLOTS; u++) begin
                h_valid[u] = 1'b0;
            end
        end else begin
            check_outputs();
            model_step();
        end
    end

    // The bound checker counts its assertion failures
    always @(negedge clock) begin
        if (uut.chk.failures != 0) begin
            $display("A bound assertion on the station outputs failed");
            $display("Test failed");
            $fatal(1, "bound assertion failed");
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic clear_inputs();
        dispatch_valid      = '0;
        dispatch_op         = '0;
        dispatch_dest       = '0;
        dispatch_src1       = '0;
        dispatch_src1_ready = '0;
        dispatch_src2       = '0;
        dispatch_src2_ready = '0;
        dispatch_br_mask    = '0;
        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            dispatch_class[k] = FU_ALU;
        end
        cdb_valid    = '0;
        cdb_tag      = '0;
        squash_valid = 1'b0;
        squash_mask  = '0;
    endtask

    task automatic advance_clock();
        @(posedge clock);
        #1;
        clear_inputs();
    endtask

    task automatic drive_lane(int k, fu_class_e cls, op_t op, tag_t dest, tag_t s1, logic r1,
                              tag_t s2, logic r2, br_mask_t mask);
        dispatch_valid[k]      = 1'b1;
        dispatch_class[k]      = cls;
        dispatch_op[k]         = op;
        dispatch_dest[k]       = dest;
        dispatch_src1[k]       = s1;
        dispatch_src1_ready[k] = r1;
        dispatch_src2[k]       = s2;
        dispatch_src2_ready[k] = r2;
        dispatch_br_mask[k]    = mask;
    endtask

    // Small tag range so broadcasts often match waiting sources
    task automatic random_inputs();
        int lanes;
        lanes = {$random(seed)} % 3;
        if (lanes > model_open()) begin
            lanes = model_open();
        end
        for (int k = 0; k < lanes; k++) begin
            dispatch_valid[k]      = 1'b1;
            dispatch_class[k]      = ($random(seed) & 1) ? FU_MULT : FU_ALU;
            dispatch_op[k]         = $random(seed);
            dispatch_dest[k]       = $random(seed) & 15;
            dispatch_src1[k]       = $random(seed) & 15;
            dispatch_src1_ready[k] = ($random(seed) & 3) != 0;
            dispatch_src2[k]       = $random(seed) & 15;
            dispatch_src2_ready[k] = ($random(seed) & 3) != 0;
            dispatch_br_mask[k]    = $random(seed) & $random(seed);
        end
        cdb_valid = $random(seed);
        for (int c = 0; c < CDB_WIDTH; c++) begin
            cdb_tag[c] = $random(seed) & 15;
        end
        alu_busy     = $random(seed) & $random(seed);
        mult_busy    = $random(seed) & $random(seed);
        squash_valid = ($random(seed) & 15) == 0;
        squash_mask  = 1 << ($random(seed) & 3);
    endtask

    initial begin
        seed      = 95576;
        test_name = "reset";
        reset     = 1'b1;
        alu_busy  = '0;
        mult_busy = '0;
        clear_inputs();
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
        assert (open_entries == DISPATCH_WIDTH)
            else fail_value("open_entries", DISPATCH_WIDTH, open_entries);
        assert (alu_valid == '0 && mult_valid == '0)
            else fail_value("issue valids", 0, {alu_valid, mult_valid});

        // Both ALUs busy for a cycle so three ready instructions compete
        test_name = "alu_order";
        alu_busy  = 2'b11;
        drive_lane(0, FU_ALU, 4'h1, 6'd1, 6'd0, 1'b1, 6'd0, 1'b1, 4'b0000);
        drive_lane(1, FU_ALU, 4'h2, 6'd2, 6'd0, 1'b1, 6'd0, 1'b1, 4'b0000);
        advance_clock();
        drive_lane(0, FU_ALU, 4'h3, 6'd3, 6'd0, 1'b1, 6'd0, 1'b1, 4'b0000);
        advance_clock();
        alu_busy = '0;
        repeat (4) advance_clock();

        test_name = "wakeup";
        drive_lane(0, FU_ALU, 4'h4, 6'd4, 6'd20, 1'b0, 6'd5, 1'b1, 4'b0000);
        repeat (3) advance_clock();
        cdb_valid[1] = 1'b1;
        cdb_tag[1]   = 6'd20;
        repeat (4) advance_clock();

        test_name = "mult_busy";
        mult_busy = 1'b1;
        for (int i = 0; i < 4; i++) begin
            drive_lane(0, FU_MULT, 4'h5, tag_t'(2 * i + 8), 6'd1, 1'b1, 6'd2, 1'b1, 4'b0000);
            drive_lane(1, FU_MULT, 4'h6, tag_t'(2 * i + 9), 6'd1, 1'b1, 6'd2, 1'b1, 4'b0000);
            advance_clock();
        end
        assert (open_entries == 0) else fail_value("open_entries", 0, open_entries);
        mult_busy = 1'b0;
        repeat (10) advance_clock();

        test_name = "squash";
        drive_lane(0, FU_ALU, 4'h7, 6'd40, 6'd30, 1'b0, 6'd1, 1'b1, 4'b0001);
        drive_lane(1, FU_ALU, 4'h8, 6'd41, 6'd30, 1'b0, 6'd1, 1'b1, 4'b0010);
        advance_clock();
        drive_lane(0, FU_ALU, 4'h9, 6'd42, 6'd1, 1'b1, 6'd1, 1'b1, 4'b0100);
        advance_clock();
        advance_clock();
        // The third instruction now sits in the issue register
        squash_valid = 1'b1;
        squash_mask  = 4'b0101;
        advance_clock();
        cdb_valid[0] = 1'b1;
        cdb_tag[0]   = 6'd30;
        repeat (5) advance_clock();

        test_name = "random";
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            random_inputs();
            advance_clock();
        end
        alu_busy  = '0;
        mult_busy = '0;
        repeat (4) advance_clock();

        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/rs_alloc.sv */
`timescale 1ns/1ps

module rs_alloc (
    input  logic [rs_pkg::DISPATCH_WIDTH-1:0]                   dispatch_valid,
    input  rs_pkg::slot_mask_t                                  free_slots,
    output rs_pkg::slot_mask_t [rs_pkg::DISPATCH_WIDTH-1:0]     lane_grant,
    output rs_pkg::count_t                                      open_entries
);
    import rs_pkg::*;

    logic [$clog2(RS_DEPTH+1)-1:0] free_cnt;

    // Lane k takes the k-th lowest free entry
    always_comb begin
        free_cnt   = '0;
        lane_grant = '0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            if (free_slots[j]) begin
                for (int k = 0; k < DISPATCH_WIDTH; k++) begin
                    if (free_cnt == k && dispatch_valid[k]) begin
                        lane_grant[k][j] = 1'b1;
                    end
                end
                free_cnt = free_cnt + 1'b1;
            end
        end
    end

    assign open_entries = (free_cnt > DISPATCH_WIDTH) ? count_t'(DISPATCH_WIDTH)
                                                      : count_t'(free_cnt);

endmodule

/* verilog/rs_entries.sv */
`timescale 1ns/1ps

module rs_entries (
    input  logic                                                clock,
    input  logic                                                reset,
    input  rs_pkg::slot_mask_t [rs_pkg::DISPATCH_WIDTH-1:0]     lane_grant,
    input  rs_pkg::fu_class_e  [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_class,
    input  rs_pkg::op_t        [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_op,
    input  rs_pkg::tag_t       [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_dest,
    input  rs_pkg::tag_t       [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_src1,
    input  logic               [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_src1_ready,
    input  rs_pkg::tag_t       [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_src2,
    input  logic               [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_src2_ready,
    input  rs_pkg::br_mask_t   [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_br_mask,
    input  logic               [rs_pkg::CDB_WIDTH-1:0]          cdb_valid,
    input  rs_pkg::tag_t       [rs_pkg::CDB_WIDTH-1:0]          cdb_tag,
    input  logic                                                squash_valid,
    input  rs_pkg::br_mask_t                                    squash_mask,
    input  rs_pkg::slot_mask_t                                  issued_slots,
    output rs_pkg::slot_mask_t                                  free_slots,
    output rs_pkg::slot_mask_t                                  alu_ready,
    output rs_pkg::slot_mask_t                                  mult_ready,
    output rs_pkg::op_t        [rs_pkg::RS_DEPTH-1:0]           entry_op,
    output rs_pkg::tag_t       [rs_pkg::RS_DEPTH-1:0]           entry_dest,
    output rs_pkg::tag_t       [rs_pkg::RS_DEPTH-1:0]           entry_src1,
    output rs_pkg::tag_t       [rs_pkg::RS_DEPTH-1:0]           entry_src2,
    output rs_pkg::br_mask_t   [rs_pkg::RS_DEPTH-1:0]           entry_br_mask
);
    import rs_pkg::*;

    slot_mask_t                 valid;
    slot_mask_t                 written;
    slot_mask_t                 squash_hit;
    slot_mask_t                 src1_ready;
    slot_mask_t                 src2_ready;
    slot_mask_t                 both_ready;
    fu_class_e [RS_DEPTH-1:0]   entry_class;
    logic [DISPATCH_WIDTH-1:0]  lane_kill;

    // Dispatch lanes already on a squashed path are not written
    always_comb begin
        written = '0;
        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            lane_kill[k] = squash_valid && ((dispatch_br_mask[k] & squash_mask) != '0);
            if (!lane_kill[k]) begin
                written = written | lane_grant[k];
            end
        end
    end

    // Entries hit by a squash this cycle never request a unit
    always_comb begin
        for (int j = 0; j < RS_DEPTH; j++) begin
            squash_hit[j] = squash_valid && ((entry_br_mask[j] & squash_mask) != '0);
            both_ready[j] = valid[j] && src1_ready[j] && src2_ready[j] && !squash_hit[j];
            alu_ready[j]  = both_ready[j] && (entry_class[j] == FU_ALU);
            mult_ready[j] = both_ready[j] && (entry_class[j] == FU_MULT);
        end
    end

    assign free_slots = ~valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~squash_hit & ~issued_slots) | written;
        end
    end

    always_ff @(posedge clock) begin
        for (int j = 0; j < RS_DEPTH; j++) begin
            // Wakeup from the data bus
            for (int c = 0; c < CDB_WIDTH; c++) begin
                if (valid[j] && cdb_valid[c] && cdb_tag[c] == entry_src1[j]) begin
                    src1_ready[j] <= 1'b1;
                end
                if (valid[j] && cdb_valid[c] && cdb_tag[c] == entry_src2[j]) begin
                    src2_ready[j] <= 1'b1;
                end
            end
            for (int k = 0; k < DISPATCH_WIDTH; k++) begin
                if (lane_grant[k][j] && !lane_kill[k]) begin
                    entry_class[j]   <= dispatch_class[k];
                    entry_op[j]      <= dispatch_op[k];
                    entry_dest[j]    <= dispatch_dest[k];
                    entry_src1[j]    <= dispatch_src1[k];
                    entry_src2[j]    <= dispatch_src2[k];
                    src1_ready[j]    <= dispatch_src1_ready[k];
                    src2_ready[j]    <= dispatch_src2_ready[k];
                    entry_br_mask[j] <= dispatch_br_mask[k];
                end
            end
        end
    end

endmodule

/* verilog/rs_issue_reg.sv */
`timescale 1ns/1ps

module rs_issue_reg #(
    parameter int NUM_UNITS = 1
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                squash_valid,
    input  rs_pkg::br_mask_t                    squash_mask,
    input  logic             [NUM_UNITS-1:0]    sel_valid,
    input  rs_pkg::op_t      [NUM_UNITS-1:0]    sel_op,
    input  rs_pkg::tag_t     [NUM_UNITS-1:0]    sel_dest,
    input  rs_pkg::tag_t     [NUM_UNITS-1:0]    sel_src1,
    input  rs_pkg::tag_t     [NUM_UNITS-1:0]    sel_src2,
    input  rs_pkg::br_mask_t [NUM_UNITS-1:0]    sel_br_mask,
    output logic             [NUM_UNITS-1:0]    issue_valid,
    output rs_pkg::op_t      [NUM_UNITS-1:0]    issue_op,
    output rs_pkg::tag_t     [NUM_UNITS-1:0]    issue_dest,
    output rs_pkg::tag_t     [NUM_UNITS-1:0]    issue_src1,
    output rs_pkg::tag_t     [NUM_UNITS-1:0]    issue_src2,
    output rs_pkg::br_mask_t [NUM_UNITS-1:0]    issue_br_mask
);
    logic [NUM_UNITS-1:0] held_valid;
    logic [NUM_UNITS-1:0] squash_hit;

    always_ff @(posedge clock) begin
        if (reset) begin
            held_valid <= '0;
        end else begin
            held_valid <= sel_valid;
        end
    end

    always_ff @(posedge clock) begin
        issue_op      <= sel_op;
        issue_dest    <= sel_dest;
        issue_src1    <= sel_src1;
        issue_src2    <= sel_src2;
        issue_br_mask <= sel_br_mask;
    end

    // A held selection on a mispredicted path never reaches its unit
    always_comb begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            squash_hit[u] = squash_valid && ((issue_br_mask[u] & squash_mask) != '0);
        end
    end

    assign issue_valid = held_valid & ~squash_hit;

endmodule

/* verilog/rs_pkg.sv */
package rs_pkg;

    // Station sizes
    localparam int RS_DEPTH       = 8;
    localparam int DISPATCH_WIDTH = 2;
    localparam int CDB_WIDTH      = 2;
    localparam int NUM_ALU        = 2;
    localparam int NUM_MULT       = 1;

    // Field widths
    localparam int TAG_BITS     = 6;
    localparam int BR_MASK_BITS = 4;
    localparam int OP_BITS      = 4;

    // Physical register tag
    typedef logic [TAG_BITS-1:0] tag_t;

    // One bit per unresolved branch
    typedef logic [BR_MASK_BITS-1:0] br_mask_t;

    typedef logic [OP_BITS-1:0] op_t;

    // One bit per entry
    typedef logic [RS_DEPTH-1:0] slot_mask_t;

    // Zero up to DISPATCH_WIDTH
    typedef logic [$clog2(DISPATCH_WIDTH+1)-1:0] count_t;

    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_class_e;

endpackage

/* verilog/rs_select.sv */
`timescale 1ns/1ps

module rs_select #(
    parameter int NUM_UNITS = rs_pkg::NUM_ALU
) (
    input  rs_pkg::slot_mask_t                              ready,
    input  logic             [NUM_UNITS-1:0]                unit_busy,
    input  rs_pkg::op_t      [rs_pkg::RS_DEPTH-1:0]         entry_op,
    input  rs_pkg::tag_t     [rs_pkg::RS_DEPTH-1:0]         entry_dest,
    input  rs_pkg::tag_t     [rs_pkg::RS_DEPTH-1:0]         entry_src1,
    input  rs_pkg::tag_t     [rs_pkg::RS_DEPTH-1:0]         entry_src2,
    input  rs_pkg::br_mask_t [rs_pkg::RS_DEPTH-1:0]         entry_br_mask,
    output rs_pkg::slot_mask_t                              grant,
    output logic             [NUM_UNITS-1:0]                sel_valid,
    output rs_pkg::op_t      [NUM_UNITS-1:0]                sel_op,
    output rs_pkg::tag_t     [NUM_UNITS-1:0]                sel_dest,
    output rs_pkg::tag_t     [NUM_UNITS-1:0]                sel_src1,
    output rs_pkg::tag_t     [NUM_UNITS-1:0]                sel_src2,
    output rs_pkg::br_mask_t [NUM_UNITS-1:0]                sel_br_mask
);
    import rs_pkg::*;

    // Each idle unit in turn takes the lowest ready entry not yet granted
    always_comb begin
        grant       = '0;
        sel_valid   = '0;
        sel_op      = '0;
        sel_dest    = '0;
        sel_src1    = '0;
        sel_src2    = '0;
        sel_br_mask = '0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (!unit_busy[u]) begin
                for (int j = 0; j < RS_DEPTH; j++) begin
                    if (!sel_valid[u] && ready[j] && !grant[j]) begin
                        grant[j]       = 1'b1;
                        sel_valid[u]   = 1'b1;
                        sel_op[u]      = entry_op[j];
                        sel_dest[u]    = entry_dest[j];
                        sel_src1[u]    = entry_src1[j];
                        sel_src2[u]    = entry_src2[j];
                        sel_br_mask[u] = entry_br_mask[j];
                    end
                end
            end
        end
    end

endmodule

/* verilog/rs_top.sv */
`timescale 1ns/1ps

module rs_top (
    input  logic                                                clock,
    input  logic                                                reset,
    input  logic               [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_valid,
    input  rs_pkg::fu_class_e  [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_class,
    input  rs_pkg::op_t        [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_op,
    input  rs_pkg::tag_t       [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_dest,
    input  rs_pkg::tag_t       [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_src1,
    input  logic               [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_src1_ready,
    input  rs_pkg::tag_t       [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_src2,
    input  logic               [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_src2_ready,
    input  rs_pkg::br_mask_t   [rs_pkg::DISPATCH_WIDTH-1:0]     dispatch_br_mask,
    output rs_pkg::count_t                                      open_entries,
    input  logic               [rs_pkg::CDB_WIDTH-1:0]          cdb_valid,
    input  rs_pkg::tag_t       [rs_pkg::CDB_WIDTH-1:0]          cdb_tag,
    input  logic                                                squash_valid,
    input  rs_pkg::br_mask_t                                    squash_mask,
    input  logic               [rs_pkg::NUM_ALU-1:0]            alu_busy,
    output logic               [rs_pkg::NUM_ALU-1:0]            alu_valid,
    output rs_pkg::op_t        [rs_pkg::NUM_ALU-1:0]            alu_op,
    output rs_pkg::tag_t       [rs_pkg::NUM_ALU-1:0]            alu_dest,
    output rs_pkg::tag_t       [rs_pkg::NUM_ALU-1:0]            alu_src1,
    output rs_pkg::tag_t       [rs_pkg::NUM_ALU-1:0]            alu_src2,
    output rs_pkg::br_mask_t   [rs_pkg::NUM_ALU-1:0]            alu_br_mask,
    input  logic               [rs_pkg::NUM_MULT-1:0]           mult_busy,
    output logic               [rs_pkg::NUM_MULT-1:0]           mult_valid,
    output rs_pkg::op_t        [rs_pkg::NUM_MULT-1:0]           mult_op,
    output rs_pkg::tag_t       [rs_pkg::NUM_MULT-1:0]           mult_dest,
    output rs_pkg::tag_t       [rs_pkg::NUM_MULT-1:0]           mult_src1,
    output rs_pkg::tag_t       [rs_pkg::NUM_MULT-1:0]           mult_src2,
    output rs_pkg::br_mask_t   [rs_pkg::NUM_MULT-1:0]           mult_br_mask
);
    import rs_pkg::*;

    slot_mask_t [DISPATCH_WIDTH-1:0]    lane_grant;
    slot_mask_t                         free_slots;
    slot_mask_t                         alu_ready;
    slot_mask_t                         mult_ready;
    slot_mask_t                         alu_grant;
    slot_mask_t                         mult_grant;
    slot_mask_t                         issued_slots;
    op_t        [RS_DEPTH-1:0]          entry_op;
    tag_t       [RS_DEPTH-1:0]          entry_dest;
    tag_t       [RS_DEPTH-1:0]          entry_src1;
    tag_t       [RS_DEPTH-1:0]          entry_src2;
    br_mask_t   [RS_DEPTH-1:0]          entry_br_mask;

    logic       [NUM_ALU-1:0]           alu_sel_valid;
    op_t        [NUM_ALU-1:0]           alu_sel_op;
    tag_t       [NUM_ALU-1:0]           alu_sel_dest;
    tag_t       [NUM_ALU-1:0]           alu_sel_src1;
    tag_t       [NUM_ALU-1:0]           alu_sel_src2;
    br_mask_t   [NUM_ALU-1:0]           alu_sel_br_mask;

    logic       [NUM_MULT-1:0]          mult_sel_valid;
    op_t        [NUM_MULT-1:0]          mult_sel_op;
    tag_t       [NUM_MULT-1:0]          mult_sel_dest;
    tag_t       [NUM_MULT-1:0]          mult_sel_src1;
    tag_t       [NUM_MULT-1:0]          mult_sel_src2;
    br_mask_t   [NUM_MULT-1:0]          mult_sel_br_mask;

    // Entries leave the table at the edge that registers them
    assign issued_slots = alu_grant | mult_grant;

    rs_alloc alloc (
        .dispatch_valid (dispatch_valid),
        .free_slots     (free_slots),
        .lane_grant     (lane_grant),
        .open_entries   (open_entries)
    );

    rs_entries entries (
        .clock               (clock),
        .reset               (reset),
        .lane_grant          (lane_grant),
        .dispatch_class      (dispatch_class),
        .dispatch_op         (dispatch_op),
        .dispatch_dest       (dispatch_dest),
        .dispatch_src1       (dispatch_src1),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src2       (dispatch_src2),
        .dispatch_src2_ready (dispatch_src2_ready),
        .dispatch_br_mask    (dispatch_br_mask),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .squash_valid        (squash_valid),
        .squash_mask         (squash_mask),
        .issued_slots        (issued_slots),
        .free_slots          (free_slots),
        .alu_ready           (alu_ready),
        .mult_ready          (mult_ready),
        .entry_op            (entry_op),
        .entry_dest          (entry_dest),
        .entry_src1          (entry_src1),
        .entry_src2          (entry_src2),
        .entry_br_mask       (entry_br_mask)
    );

    rs_select #(.NUM_UNITS(NUM_ALU)) alu_select (
        .ready         (alu_ready),
        .unit_busy     (alu_busy),
        .entry_op      (entry_op),
        .entry_dest    (entry_dest),
        .entry_src1    (entry_src1),
        .entry_src2    (entry_src2),
        .entry_br_mask (entry_br_mask),
        .grant         (alu_grant),
        .sel_valid     (alu_sel_valid),
        .sel_op        (alu_sel_op),
        .sel_dest      (alu_sel_dest),
        .sel_src1      (alu_sel_src1),
        .sel_src2      (alu_sel_src2),
        .sel_br_mask   (alu_sel_br_mask)
    );

    rs_select #(.NUM_UNITS(NUM_MULT)) mult_select (
        .ready         (mult_ready),
        .unit_busy     (mult_busy),
        .entry_op      (entry_op),
        .entry_dest    (entry_dest),
        .entry_src1    (entry_src1),
        .entry_src2    (entry_src2),
        .entry_br_mask (entry_br_mask),
        .grant         (mult_grant),
        .sel_valid     (mult_sel_valid),
        .sel_op        (mult_sel_op),
        .sel_dest      (mult_sel_dest),
        .sel_src1      (mult_sel_src1),
        .sel_src2      (mult_sel_src2),
        .sel_br_mask   (mult_sel_br_mask)
    );

    rs_issue_reg #(.NUM_UNITS(NUM_ALU)) alu_issue (
        .clock         (clock),
        .reset         (reset),
        .squash_valid  (squash_valid),
        .squash_mask   (squash_mask),
        .sel_valid     (alu_sel_valid),
        .sel_op        (alu_sel_op),
        .sel_dest      (alu_sel_dest),
        .sel_src1      (alu_sel_src1),
        .sel_src2      (alu_sel_src2),
        .sel_br_mask   (alu_sel_br_mask),
        .issue_valid   (alu_valid),
        .issue_op      (alu_op),
        .issue_dest    (alu_dest),
        .issue_src1    (alu_src1),
        .issue_src2    (alu_src2),
        .issue_br_mask (alu_br_mask)
    );

    rs_issue_reg #(.NUM_UNITS(NUM_MULT)) mult_issue (
        .clock         (clock),
        .reset         (reset),
        .squash_valid  (squash_valid),
        .squash_mask   (squash_mask),
        .sel_valid     (mult_sel_valid),
        .sel_op        (mult_sel_op),
        .sel_dest      (mult_sel_dest),
        .sel_src1      (mult_sel_src1),
        .sel_src2      (mult_sel_src2),
        .sel_br_mask   (mult_sel_br_mask),
        .issue_valid   (mult_valid),
        .issue_op      (mult_op),
        .issue_dest    (mult_dest),
        .issue_src1    (mult_src1),
        .issue_src2    (mult_src2),
        .issue_br_mask (mult_br_mask)
    );

endmodule
